// ==== design/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // datapath and address width
    localparam int unsigned xlen = 32;

    // pc bits below this are always zero for rv32i without compressed
    localparam int unsigned pc_lsb = 2;

    // local side
    // history bits kept per table entry
    localparam int unsigned lhist_bits = 6;
    // history table index, pc[7:2]
    localparam int unsigned lht_index_bits = 6;

    // gshare side
    // global history length
    localparam int unsigned ghr_bits = 8;
    // shared by gshare pattern table and chooser, pc[9:2]
    localparam int unsigned gtable_index_bits = 8;

    // branch target buffer
    // index is pc[6:2]
    localparam int unsigned btb_index_bits = 5;
    // tag is pc[31:7]
    localparam int unsigned btb_tag_lsb = btb_index_bits + pc_lsb;
    localparam int unsigned btb_tag_bits = xlen - btb_tag_lsb;

    // 2-bit saturating counter encodings
    localparam int unsigned ctr_bits = 2;
    localparam logic [ctr_bits-1:0] ctr_strong_nt = 2'b00;
    localparam logic [ctr_bits-1:0] ctr_weak_nt = 2'b01;
    localparam logic [ctr_bits-1:0] ctr_weak_t = 2'b10;
    localparam logic [ctr_bits-1:0] ctr_strong_t = 2'b11;

    // pattern counters come out of reset weakly not taken
    // chooser comes out of reset leaning local
    localparam logic [ctr_bits-1:0] ctr_chooser_init = 2'b01;

    // counter at or above this value predicts taken
    // for the chooser it selects gshare
    localparam logic [ctr_bits-1:0] ctr_taken_min = ctr_weak_t;

endpackage

`default_nettype wire

// ==== design/sat_counter_table.sv ====
`default_nettype none

module sat_counter_table
    import bp_pkg::*;
#(
    parameter int unsigned depth_bits = 6,
    parameter logic [ctr_bits-1:0] init_value = ctr_weak_nt
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // read port a, lookup side
    input  logic [depth_bits-1:0] rd_index_a,
    output logic [ctr_bits-1:0]   rd_ctr_a,
    // read port b, resolve side
    input  logic [depth_bits-1:0] rd_index_b,
    output logic [ctr_bits-1:0]   rd_ctr_b,
    // training port
    input  logic                  upd_en,
    input  logic [depth_bits-1:0] upd_index,
    input  logic                  upd_taken
);

    // one 2-bit counter per entry
    logic [ctr_bits-1:0] ctrs [2**depth_bits];

    // current and next value of the entry being trained
    logic [ctr_bits-1:0] upd_ctr;
    logic [ctr_bits-1:0] upd_next;

    // reads see the array before this edge's update
    assign rd_ctr_a = ctrs[rd_index_a];
    assign rd_ctr_b = ctrs[rd_index_b];

    assign upd_ctr = ctrs[upd_index];

    // saturate at both ends
    always_comb begin
        upd_next = upd_ctr;
        if (upd_taken) begin
            if (upd_ctr != ctr_strong_t) begin
                upd_next = upd_ctr + ctr_bits'(1);
            end
        end else begin
            if (upd_ctr != ctr_strong_nt) begin
                upd_next = upd_ctr - ctr_bits'(1);
            end
        end
    end

    // all entries back to init on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**depth_bits; i++) begin
                ctrs[i] <= init_value;
            end
        end else if (upd_en) begin
            ctrs[upd_index] <= upd_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/local_predictor.sv ====
`default_nettype none

module local_predictor
    import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    // lookup
    input  logic [xlen-1:0] predict_pc,
    output logic            local_taken,
    // resolve
    input  logic            resolve_valid,
    input  logic [xlen-1:0] resolve_pc,
    input  logic            resolve_taken,
    output logic            resolve_local_taken
);

    // per-pc history, newest outcome in bit 0
    logic [lhist_bits-1:0] lht [2**lht_index_bits];

    logic [lht_index_bits-1:0] pred_lht_index;
    logic [lht_index_bits-1:0] res_lht_index;
    logic [lhist_bits-1:0]     pred_hist;
    logic [lhist_bits-1:0]     res_hist;
    logic [ctr_bits-1:0]       pred_ctr;
    logic [ctr_bits-1:0]       res_ctr;

    // history table picked by low pc bits above the word offset
    assign pred_lht_index = predict_pc[lht_index_bits+pc_lsb-1:pc_lsb];
    assign res_lht_index = resolve_pc[lht_index_bits+pc_lsb-1:pc_lsb];

    // old history, before this edge's shift
    assign pred_hist = lht[pred_lht_index];
    assign res_hist = lht[res_lht_index];

    // pattern counters indexed by history alone
    sat_counter_table #(
        .depth_bits (lhist_bits),
        .init_value (ctr_weak_nt)
    ) u_local_pht (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index_a (pred_hist),
        .rd_ctr_a   (pred_ctr),
        .rd_index_b (res_hist),
        .rd_ctr_b   (res_ctr),
        .upd_en     (resolve_valid),
        // train the counter under the old history
        .upd_index  (res_hist),
        .upd_taken  (resolve_taken)
    );

    assign local_taken = (pred_ctr >= ctr_taken_min);

    // what local would have said for the resolving branch
    assign resolve_local_taken = (res_ctr >= ctr_taken_min);

    // shift the outcome into that pc's history
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**lht_index_bits; i++) begin
                lht[i] <= '0;
            end
        end else if (resolve_valid) begin
            lht[res_lht_index] <= {res_hist[lhist_bits-2:0], resolve_taken};
        end
    end

endmodule

`default_nettype wire

// ==== design/gshare_predictor.sv ====
`default_nettype none

module gshare_predictor
    import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    // lookup
    input  logic [xlen-1:0] predict_pc,
    output logic            global_taken,
    // resolve
    input  logic            resolve_valid,
    input  logic [xlen-1:0] resolve_pc,
    input  logic            resolve_taken,
    output logic            resolve_global_taken
);

    // global outcome history, newest in bit 0
    logic [ghr_bits-1:0] ghr;

    logic [gtable_index_bits-1:0] pred_index;
    logic [gtable_index_bits-1:0] res_index;
    logic [ctr_bits-1:0]          pred_ctr;
    logic [ctr_bits-1:0]          res_ctr;

    // pc hashed with history, both sides use the pre-edge ghr
    assign pred_index = predict_pc[gtable_index_bits+pc_lsb-1:pc_lsb] ^ ghr;
    assign res_index = resolve_pc[gtable_index_bits+pc_lsb-1:pc_lsb] ^ ghr;

    sat_counter_table #(
        .depth_bits (gtable_index_bits),
        .init_value (ctr_weak_nt)
    ) u_gshare_pht (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index_a (pred_index),
        .rd_ctr_a   (pred_ctr),
        .rd_index_b (res_index),
        .rd_ctr_b   (res_ctr),
        .upd_en     (resolve_valid),
        .upd_index  (res_index),
        .upd_taken  (resolve_taken)
    );

    assign global_taken = (pred_ctr >= ctr_taken_min);
    assign resolve_global_taken = (res_ctr >= ctr_taken_min);

    // history moves only on resolve, never speculatively
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ghr <= '0;
        end else if (resolve_valid) begin
            ghr <= {ghr[ghr_bits-2:0], resolve_taken};
        end
    end

endmodule

`default_nettype wire

// ==== design/branch_target_buffer.sv ====
`default_nettype none

module branch_target_buffer
    import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    // lookup
    input  logic [xlen-1:0] predict_pc,
    output logic            btb_hit,
    output logic [xlen-1:0] btb_target,
    // resolve
    input  logic            resolve_valid,
    input  logic [xlen-1:0] resolve_pc,
    input  logic            resolve_taken,
    input  logic [xlen-1:0] resolve_target
);

    // direct mapped, one way
    logic                    valid   [2**btb_index_bits];
    logic [btb_tag_bits-1:0] tags    [2**btb_index_bits];
    logic [xlen-1:0]         targets [2**btb_index_bits];

    logic [btb_index_bits-1:0] pred_index;
    logic [btb_tag_bits-1:0]   pred_tag;
    logic [btb_index_bits-1:0] res_index;
    logic [btb_tag_bits-1:0]   res_tag;
    logic                      fill;

    // index pc[6:2], tag pc[31:7]
    assign pred_index = predict_pc[btb_tag_lsb-1:pc_lsb];
    assign pred_tag = predict_pc[xlen-1:btb_tag_lsb];
    assign res_index = resolve_pc[btb_tag_lsb-1:pc_lsb];
    assign res_tag = resolve_pc[xlen-1:btb_tag_lsb];

    // lookup reads pre-edge contents
    assign btb_hit = valid[pred_index] && (tags[pred_index] == pred_tag);
    assign btb_target = targets[pred_index];

    // only taken branches allocate or refresh an entry
    assign fill = resolve_valid && resolve_taken;

    // valid bits are control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**btb_index_bits; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (fill) begin
            valid[res_index] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (fill) begin
            tags[res_index] <= res_tag;
            targets[res_index] <= resolve_target;
        end
    end

endmodule

`default_nettype wire

// ==== design/tournament_predictor.sv ====
`default_nettype none

module tournament_predictor
    import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    // fetch side lookup
    input  logic            predict_req,
    input  logic [xlen-1:0] predict_pc,
    // registered prediction one cycle after the request
    output logic            pred_valid,
    output logic            pred_taken,
    output logic [xlen-1:0] pred_target,
    output logic            pred_hit,
    // execute side resolve
    input  logic            resolve_valid,
    input  logic [xlen-1:0] resolve_pc,
    input  logic            resolve_taken,
    input  logic [xlen-1:0] resolve_target
);

    // component outputs
    logic            local_taken;
    logic            global_taken;
    logic            resolve_local_taken;
    logic            resolve_global_taken;
    logic            btb_hit;
    logic [xlen-1:0] btb_target;

    // chooser
    logic [gtable_index_bits-1:0] pred_choice_index;
    logic [gtable_index_bits-1:0] res_choice_index;
    logic [ctr_bits-1:0]          pred_choice;
    logic                         components_differ;
    logic                         use_gshare;

    // next-cycle output values
    logic            next_taken;
    logic [xlen-1:0] next_target;

    local_predictor u_local (
        .clk                 (clk),
        .rst_n               (rst_n),
        .predict_pc          (predict_pc),
        .local_taken         (local_taken),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_local_taken (resolve_local_taken)
    );

    gshare_predictor u_gshare (
        .clk                  (clk),
        .rst_n                (rst_n),
        .predict_pc           (predict_pc),
        .global_taken         (global_taken),
        .resolve_valid        (resolve_valid),
        .resolve_pc           (resolve_pc),
        .resolve_taken        (resolve_taken),
        .resolve_global_taken (resolve_global_taken)
    );

    branch_target_buffer u_btb (
        .clk            (clk),
        .rst_n          (rst_n),
        .predict_pc     (predict_pc),
        .btb_hit        (btb_hit),
        .btb_target     (btb_target),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target)
    );

    // chooser indexed by plain pc[9:2] without history
    assign pred_choice_index = predict_pc[gtable_index_bits+pc_lsb-1:pc_lsb];
    assign res_choice_index = resolve_pc[gtable_index_bits+pc_lsb-1:pc_lsb];

    // train only when the two sides disagreed
    assign components_differ = resolve_local_taken != resolve_global_taken;

    // counts up toward gshare when gshare was the correct one
    sat_counter_table #(
        .depth_bits (gtable_index_bits),
        .init_value (ctr_chooser_init)
    ) u_chooser (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index_a (pred_choice_index),
        .rd_ctr_a   (pred_choice),
        .rd_index_b (res_choice_index),
        .rd_ctr_b   (),
        .upd_en     (resolve_valid && components_differ),
        .upd_index  (res_choice_index),
        .upd_taken  (resolve_global_taken == resolve_taken)
    );

    assign use_gshare = (pred_choice >= ctr_taken_min);

    // no btb entry means no target so fall through
    assign next_taken = btb_hit && (use_gshare ? global_taken : local_taken);
    assign next_target = btb_hit ? btb_target : predict_pc + xlen'(4);

    // valid strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= predict_req;
        end
    end

    // payload follows the lookup every cycle
    always_ff @(posedge clk) begin
        pred_taken <= next_taken;
        pred_target <= next_target;
        pred_hit <= btb_hit;
    end

endmodule

`default_nettype wire

// ==== testbench/tournament_predictor_properties.sv ====
`default_nettype none

module tournament_predictor_properties
    import bp_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input logic            predict_req,
    input logic [xlen-1:0] predict_pc,
    input logic            pred_valid,
    input logic            pred_taken,
    input logic [xlen-1:0] pred_target,
    input logic            pred_hit
);

    timeunit 1ns;
    timeprecision 10ps;

    // read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // one-cycle lookup latency
    valid_follows_req: assert property (@(posedge clk)
        rst_n |=> (pred_valid == $past(predict_req)))
        else begin
            $error("pred_valid did not follow predict_req by one cycle");
            fail_count++;
        end

    // valid flop cleared by reset
    valid_low_in_reset: assert property (@(posedge clk) !rst_n |=> !pred_valid)
        else begin
            $error("pred_valid high after a reset cycle");
            fail_count++;
        end

    // no target to jump to without a btb entry
    no_taken_on_miss: assert property (@(posedge clk) pred_valid |-> !(pred_taken && !pred_hit))
        else begin
            $error("pred_taken high while pred_hit low");
            fail_count++;
        end

    // fall-through target on a miss
    miss_target_is_next_pc: assert property (@(posedge clk)
        (pred_valid && !pred_hit) |-> (pred_target == $past(predict_pc) + xlen'(4)))
        else begin
            $error("miss target is not the previous lookup pc plus 4");
            fail_count++;
        end

endmodule

bind tournament_predictor tournament_predictor_properties props (
    .clk         (clk),
    .rst_n       (rst_n),
    .predict_req (predict_req),
    .predict_pc  (predict_pc),
    .pred_valid  (pred_valid),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .pred_hit    (pred_hit)
);

`default_nettype wire

// ==== testbench/tb_tournament_predictor.sv ====
`default_nettype none

module tb_tournament_predictor
    import bp_pkg::*;
();

    timeunit 1ns;
    timeprecision 10ps;

    localparam int clk_period = 100;
    localparam int reset_cycles = 16;
    // stimulus steps per test plus one drain step each
    localparam int total_cycles = reset_cycles + 8 + 10 + 80 + 2 * 128 + 3 + 400 + 8;
    localparam int margin_cycles = 200;

    // branches used by the directed tests
    localparam logic [xlen-1:0] pc_a = 32'h0000_2040;
    localparam logic [xlen-1:0] pc_b = 32'h0000_3080;
    localparam logic [xlen-1:0] pc_c1 = 32'h0000_4104;
    localparam logic [xlen-1:0] pc_c2 = 32'h0000_4208;

    logic            clk;
    logic            rst_n;
    logic            predict_req;
    logic [xlen-1:0] predict_pc;
    logic            pred_valid;
    logic            pred_taken;
    logic [xlen-1:0] pred_target;
    logic            pred_hit;
    logic            resolve_valid;
    logic [xlen-1:0] resolve_pc;
    logic            resolve_taken;
    logic [xlen-1:0] resolve_target;

    // reference model state
    logic [lhist_bits-1:0]   m_lht [2**lht_index_bits];
    logic [ctr_bits-1:0]     m_lpht [2**lhist_bits];
    logic [ctr_bits-1:0]     m_gpht [2**gtable_index_bits];
    logic [ctr_bits-1:0]     m_chooser [2**gtable_index_bits];
    logic [ghr_bits-1:0]     m_ghr;
    logic                    m_btb_valid [2**btb_index_bits];
    logic [btb_tag_bits-1:0] m_btb_tag [2**btb_index_bits];
    logic [xlen-1:0]         m_btb_target [2**btb_index_bits];

    // expected {valid, hit, taken, target} per cycle and the lookup pc
    logic [xlen+2:0] exp_q [$];
    logic [xlen-1:0] exp_pc_q [$];
    // last direction the DUT gave per pc for accuracy counts
    logic            last_pred [logic [xlen-1:0]];

    string test_name;
    int    checks = 0;
    int    errors = 0;
    int    test_checks = 0;
    int    test_errors = 0;
    int    correct = 0;
    int    incorrect = 0;

    tournament_predictor DUT (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [ctr_bits-1:0] saturate(input logic [ctr_bits-1:0] c,
                                                     input logic up);
        if (up) begin
            return (c == ctr_strong_t) ? c : c + 2'd1;
        end
        return (c == ctr_strong_nt) ? c : c - 2'd1;
    endfunction

    // {hit, taken, target} from the model before any update this cycle
    function automatic logic [xlen+1:0] model_predict(input logic [xlen-1:0] pc);
        logic [lhist_bits-1:0]        hist;
        logic [gtable_index_bits-1:0] cidx;
        logic [btb_index_bits-1:0]    bidx;
        logic                         local_t;
        logic                         global_t;
        logic                         hit;
        logic                         taken;
        hist = m_lht[pc[pc_lsb +: lht_index_bits]];
        cidx = pc[pc_lsb +: gtable_index_bits];
        bidx = pc[pc_lsb +: btb_index_bits];
        local_t = m_lpht[hist] >= ctr_taken_min;
        global_t = m_gpht[cidx ^ m_ghr] >= ctr_taken_min;
        hit = m_btb_valid[bidx] && (m_btb_tag[bidx] == pc[xlen-1:btb_tag_lsb]);
        taken = hit && ((m_chooser[cidx] >= ctr_taken_min) ? global_t : local_t);
        return {hit, taken, hit ? m_btb_target[bidx] : pc + 32'd4};
    endfunction

    function automatic void model_resolve(input logic [xlen-1:0] pc, input logic taken,
                                          input logic [xlen-1:0] target);
        logic [lht_index_bits-1:0]    lidx;
        logic [lhist_bits-1:0]        hist;
        logic [gtable_index_bits-1:0] cidx;
        logic [gtable_index_bits-1:0] gidx;
        logic [btb_index_bits-1:0]    bidx;
        logic                         local_t;
        logic                         global_t;
        lidx = pc[pc_lsb +: lht_index_bits];
        hist = m_lht[lidx];
        cidx = pc[pc_lsb +: gtable_index_bits];
        gidx = cidx ^ m_ghr;
        bidx = pc[pc_lsb +: btb_index_bits];
        local_t = m_lpht[hist] >= ctr_taken_min;
        global_t = m_gpht[gidx] >= ctr_taken_min;
        // chooser learns only from disagreement
        // up means gshare was right
        if (local_t != global_t) begin
            m_chooser[cidx] = saturate(m_chooser[cidx], global_t == taken);
        end
        m_lpht[hist] = saturate(m_lpht[hist], taken);
        m_gpht[gidx] = saturate(m_gpht[gidx], taken);
        m_lht[lidx] = {hist[lhist_bits-2:0], taken};
        m_ghr = {m_ghr[ghr_bits-2:0], taken};
        if (taken) begin
            m_btb_valid[bidx] = 1'b1;
            m_btb_tag[bidx] = pc[xlen-1:btb_tag_lsb];
            m_btb_target[bidx] = target;
        end
    endfunction

    function automatic void check_value(input string what, input logic [xlen-1:0] exp,
                                        input logic [xlen-1:0] act);
        checks++;
        test_checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endfunction

    // outputs of last cycle's lookup are stable at the falling edge
    function automatic void check_outputs();
        logic [xlen+2:0] e;
        logic [xlen-1:0] p;
        if (exp_q.size() == 0) begin
            return;
        end
        e = exp_q.pop_front();
        p = exp_pc_q.pop_front();
        check_value("pred_valid", 32'(e[xlen+2]), 32'(pred_valid));
        if (e[xlen+2]) begin
            check_value("pred_hit", 32'(e[xlen+1]), 32'(pred_hit));
            check_value("pred_taken", 32'(e[xlen]), 32'(pred_taken));
            check_value("pred_target", e[xlen-1:0], pred_target);
            last_pred[p] = pred_taken;
        end
    endfunction

    // one cycle of stimulus driven on the falling edge
    task automatic step(input logic req, input logic [xlen-1:0] pc, input logic rv,
                        input logic [xlen-1:0] rpc, input logic rtaken,
                        input logic [xlen-1:0] rtarget);
        @(negedge clk);
        check_outputs();
        predict_req = req;
        predict_pc = pc;
        resolve_valid = rv;
        resolve_pc = rpc;
        resolve_taken = rtaken;
        resolve_target = rtarget;
        // lookup sees the tables before this cycle's resolve
        exp_q.push_back({req, model_predict(pc)});
        exp_pc_q.push_back(pc);
        if (rv) begin
            if (last_pred.exists(rpc)) begin
                if (last_pred[rpc] == rtaken) begin
                    correct++;
                end else begin
                    incorrect++;
                end
            end
            model_resolve(rpc, rtaken, rtarget);
        end
    endtask

    // idle step so the last lookup gets compared
    // then the per-test line
    task automatic report_test();
        step(1'b0, '0, 1'b0, '0, 1'b0, '0);
        $display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // four pcs plus four aliases with another tag
    function automatic logic [xlen-1:0] mix_pc(input logic [2:0] pick);
        return (pick[2] ? 32'h1000_5000 : 32'h0000_5000) + {28'd0, pick[1:0], 2'b00};
    endfunction

    initial begin
        #((total_cycles + margin_cycles) * clk_period);
        $display("watchdog expired after %0d cycles", total_cycles + margin_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic outcome;
        int   prop_failures;
        void'($urandom(32'he57));
        clk = 1'b0;
        rst_n = 1'b0;
        predict_req = 1'b0;
        predict_pc = '0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_taken = 1'b0;
        resolve_target = '0;
        m_lht = '{default: '0};
        m_lpht = '{default: ctr_weak_nt};
        m_gpht = '{default: ctr_weak_nt};
        m_chooser = '{default: ctr_chooser_init};
        m_ghr = '0;
        m_btb_valid = '{default: 1'b0};
        m_btb_tag = '{default: '0};
        m_btb_target = '{default: '0};
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // empty btb so every lookup falls through
        test_name = "reset_state";
        for (int i = 0; i < 8; i++) begin
            step(1'b1, 32'h0000_1000 + 32'(i * 4), 1'b0, '0, 1'b0, '0);
        end
        report_test();

        test_name = "train_and_fill";
        for (int i = 0; i < 10; i++) begin
            step(1'b1, pc_a, 1'b1, pc_a, 1'b1, 32'h0000_2100);
        end
        check_value("trained taken", 32'h3, 32'(model_predict(pc_a) >> xlen));
        report_test();

        // T N T N on one branch that local history catches
        test_name = "local_alternating";
        for (int i = 0; i < 80; i++) begin
            step(1'b1, pc_b, 1'b1, pc_b, i % 2 == 0, 32'h0000_3000);
        end
        check_value("chooser on local", 32'd1,
                    32'(m_chooser[pc_b[pc_lsb +: gtable_index_bits]] < ctr_taken_min));
        report_test();

        // c2 repeats c1's random outcome which only global history sees
        test_name = "chooser_switch";
        for (int i = 0; i < 128; i++) begin
            outcome = 1'($urandom());
            step(1'b1, pc_c1, 1'b1, pc_c1, outcome, 32'h0000_4400);
            step(1'b1, pc_c2, 1'b1, pc_c2, outcome, 32'h0000_4800);
        end
        check_value("chooser on gshare", 32'd1,
                    32'(m_chooser[pc_c2[pc_lsb +: gtable_index_bits]] >= ctr_taken_min));
        report_test();

        // lookup and resolve of one pc in one cycle with a retarget in the middle
        test_name = "same_cycle";
        step(1'b1, pc_a, 1'b1, pc_a, 1'b0, 32'h0000_2100);
        step(1'b1, pc_a, 1'b1, pc_a, 1'b1, 32'h0000_2200);
        step(1'b1, pc_a, 1'b0, '0, 1'b0, '0);
        report_test();

        test_name = "random_mix";
        for (int i = 0; i < 400; i++) begin
            outcome = 1'($urandom());
            step($urandom_range(0, 3) != 0, mix_pc(3'($urandom_range(0, 7))),
                 $urandom_range(0, 4) < 3, mix_pc(3'($urandom_range(0, 7))), outcome,
                 32'h0000_6000 + 32'($urandom_range(0, 15) * 4));
        end
        report_test();

        @(negedge clk);
        check_outputs();
        prop_failures = int'(DUT.props.fail_count);
        $display("summary: %0d checks, %0d errors, %0d property failures, %0d right, %0d wrong",
                 checks, errors, prop_failures, correct, incorrect);
        if (errors == 0 && prop_failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/bp_pkg.sv
design/sat_counter_table.sv
design/local_predictor.sv
design/gshare_predictor.sv
design/branch_target_buffer.sv
design/tournament_predictor.sv
testbench/tournament_predictor_properties.sv
testbench/tb_tournament_predictor.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_tournament_predictor
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
